/* rtl/cpu_pkg.sv */
package cpu_pkg;

    typedef logic [31:0] data_t;     // Register and ALU word
    typedef logic [31:0] pc_t;       // Byte address of an instruction
    typedef logic [31:0] inst_t;
    typedef logic [3:0]  reg_idx_t;  // Sixteen registers
    typedef logic [15:0] imm_t;
    typedef logic [9:0]  ledr_t;
    typedef logic [23:0] hex_t;

    localparam pc_t inst_size = 32'd4;

    // Primary opcode, inst[31:26]
    typedef enum logic [5:0] {
        OP1_ALUR = 6'b000000,
        OP1_BEQ  = 6'b001000,
        OP1_BLT  = 6'b001001,
        OP1_BLE  = 6'b001010,
        OP1_BNE  = 6'b001011,
        OP1_JAL  = 6'b001100,
        OP1_SW   = 6'b011010,
        OP1_ADDI = 6'b100000,
        OP1_ANDI = 6'b100100,
        OP1_ORI  = 6'b100101,
        OP1_XORI = 6'b100110
    } op1_e;

    // Secondary opcode for ALUR, inst[25:18]
    typedef enum logic [7:0] {
        OP2_EQ   = 8'b00001000,
        OP2_LT   = 8'b00001001,
        OP2_LE   = 8'b00001010,
        OP2_NE   = 8'b00001011,
        OP2_ADD  = 8'b00100000,
        OP2_AND  = 8'b00100100,
        OP2_OR   = 8'b00100101,
        OP2_XOR  = 8'b00100110,
        OP2_SUB  = 8'b00101000,
        OP2_NAND = 8'b00101100,
        OP2_NOR  = 8'b00101101,
        OP2_NXOR = 8'b00101110,
        OP2_RSHF = 8'b00110000,
        OP2_LSHF = 8'b00110001
    } op2_e;

    typedef struct packed {
        logic     valid;
        op1_e     op1;
        op2_e     op2;
        pc_t      pc_plus;
        data_t    rs_val;
        data_t    rt_val;
        data_t    imm;       // Already sign-extended
        reg_idx_t dst;
        logic     wr_reg;
        logic     is_store;
    } id_ex_t;

    typedef struct packed {
        logic     wr_reg;
        reg_idx_t dst;
        data_t    result;
        logic     st_en;
        data_t    st_addr;
        data_t    st_data;
    } ex_wb_t;

    typedef struct packed {
        logic taken;
        pc_t  target;
    } redirect_t;

    // One bypass source
    typedef struct packed {
        logic     wr_reg;
        reg_idx_t dst;
        data_t    value;
    } fwd_t;

endpackage

/* rtl/fetch_stage.sv */
module fetch_stage #(
    parameter cpu_pkg::pc_t START_PC = 32'h100
) (
    input  logic               clk,
    input  logic               reset,
    input  cpu_pkg::redirect_t redirect,
    output cpu_pkg::pc_t       imem_addr,
    input  cpu_pkg::inst_t     imem_data,
    output cpu_pkg::inst_t     fetch_inst,
    output cpu_pkg::pc_t       fetch_pc_plus,
    output logic               fetch_valid
);

    cpu_pkg::pc_t pc;
    cpu_pkg::pc_t pc_next;
    cpu_pkg::pc_t inflight_pc_plus;  // pc_plus of the word the ROM returns now
    logic         inflight_valid;

    assign pc_next = pc + cpu_pkg::inst_size;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc             <= START_PC;
            inflight_valid <= 1'b0;
        end else begin
            pc             <= redirect.taken ? redirect.target : pc_next;
            inflight_valid <= !redirect.taken;  // Word fetched on the wrong path
        end
    end

    always_ff @(posedge clk) begin
        inflight_pc_plus <= pc_next;
    end

    assign imem_addr     = pc;
    assign fetch_inst    = imem_data;
    assign fetch_pc_plus = inflight_pc_plus;
    assign fetch_valid   = inflight_valid;

endmodule

/* rtl/decode_stage.sv */
module decode_stage (
    input  logic               clk,
    input  logic               reset,
    input  cpu_pkg::inst_t     fetch_inst,
    input  cpu_pkg::pc_t       fetch_pc_plus,
    input  logic               fetch_valid,
    input  cpu_pkg::redirect_t redirect,
    input  cpu_pkg::fwd_t      ex_fwd,
    input  cpu_pkg::fwd_t      wb_fwd,
    output cpu_pkg::id_ex_t    id_ex
);

    cpu_pkg::op1_e     op1;
    cpu_pkg::op2_e     op2;
    cpu_pkg::reg_idx_t rd;
    cpu_pkg::reg_idx_t rs;
    cpu_pkg::reg_idx_t rt;
    cpu_pkg::imm_t     imm;
    logic              known_op;
    logic              writes_reg;
    logic              inst_valid;
    cpu_pkg::data_t    regs [2**$bits(cpu_pkg::reg_idx_t)];
    cpu_pkg::id_ex_t   id_ex_d;

    // Youngest producer wins, then the register file
    function automatic cpu_pkg::data_t bypass(
        input cpu_pkg::reg_idx_t idx,
        input cpu_pkg::fwd_t     ex_src,
        input cpu_pkg::fwd_t     wb_src,
        input cpu_pkg::data_t    rf_val
    );
        if (ex_src.wr_reg && ex_src.dst == idx)
            return ex_src.value;
        if (wb_src.wr_reg && wb_src.dst == idx)
            return wb_src.value;
        return rf_val;
    endfunction

    assign op1 = cpu_pkg::op1_e'(fetch_inst[31:26]);
    assign op2 = cpu_pkg::op2_e'(fetch_inst[25:18]);
    assign imm = fetch_inst[23:8];
    assign rd  = fetch_inst[11:8];
    assign rs  = fetch_inst[7:4];
    assign rt  = fetch_inst[3:0];

    always_comb begin
        known_op   = 1'b1;
        writes_reg = 1'b0;
        case (op1)
            cpu_pkg::OP1_ALUR, cpu_pkg::OP1_JAL,
            cpu_pkg::OP1_ADDI, cpu_pkg::OP1_ANDI,
            cpu_pkg::OP1_ORI,  cpu_pkg::OP1_XORI: writes_reg = 1'b1;
            cpu_pkg::OP1_BEQ,  cpu_pkg::OP1_BLT,
            cpu_pkg::OP1_BLE,  cpu_pkg::OP1_BNE,
            cpu_pkg::OP1_SW:                      writes_reg = 1'b0;
            default:                              known_op   = 1'b0;
        endcase
    end

    // Zero word or unknown opcode becomes a bubble
    assign inst_valid = fetch_valid && known_op && (fetch_inst != '0);

    always_comb begin
        id_ex_d          = '0;
        id_ex_d.valid    = inst_valid;
        id_ex_d.op1      = op1;
        id_ex_d.op2      = op2;
        id_ex_d.pc_plus  = fetch_pc_plus;
        id_ex_d.rs_val   = bypass(rs, ex_fwd, wb_fwd, regs[rs]);
        id_ex_d.rt_val   = bypass(rt, ex_fwd, wb_fwd, regs[rt]);
        id_ex_d.imm      = {{16{imm[15]}}, imm};
        id_ex_d.dst      = (op1 == cpu_pkg::OP1_ALUR) ? rd : rt;
        id_ex_d.wr_reg   = inst_valid && writes_reg;
        id_ex_d.is_store = inst_valid && (op1 == cpu_pkg::OP1_SW);
    end

    // Register file written at the end of write-back
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < $size(regs); i++)
                regs[i] <= '0;
        end else if (wb_fwd.wr_reg) begin
            regs[wb_fwd.dst] <= wb_fwd.value;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            id_ex <= '0;
        else if (redirect.taken)
            id_ex <= '0;  // Flush the younger instruction
        else
            id_ex <= id_ex_d;
    end

endmodule

/* rtl/alu_unit.sv */
module alu_unit (
    input  cpu_pkg::id_ex_t id_ex,
    output cpu_pkg::data_t  alu_result
);

    cpu_pkg::data_t a;
    cpu_pkg::data_t b;

    assign a = id_ex.rs_val;
    // Immediate forms take the sign-extended field
    assign b = (id_ex.op1 == cpu_pkg::OP1_ALUR) ? id_ex.rt_val : id_ex.imm;

    always_comb begin
        alu_result = '0;
        case (id_ex.op1)
            cpu_pkg::OP1_ALUR: begin
                case (id_ex.op2)
                    cpu_pkg::OP2_EQ:   alu_result = cpu_pkg::data_t'(a == b);
                    cpu_pkg::OP2_LT:   alu_result = cpu_pkg::data_t'($signed(a) < $signed(b));
                    cpu_pkg::OP2_LE:   alu_result = cpu_pkg::data_t'($signed(a) <= $signed(b));
                    cpu_pkg::OP2_NE:   alu_result = cpu_pkg::data_t'(a != b);
                    cpu_pkg::OP2_ADD:  alu_result = a + b;
                    cpu_pkg::OP2_AND:  alu_result = a & b;
                    cpu_pkg::OP2_OR:   alu_result = a | b;
                    cpu_pkg::OP2_XOR:  alu_result = a ^ b;
                    cpu_pkg::OP2_SUB:  alu_result = a - b;
                    cpu_pkg::OP2_NAND: alu_result = ~(a & b);
                    cpu_pkg::OP2_NOR:  alu_result = ~(a | b);
                    cpu_pkg::OP2_NXOR: alu_result = ~(a ^ b);
                    cpu_pkg::OP2_RSHF: alu_result = $signed(a) >>> b;  // Sign fill
                    cpu_pkg::OP2_LSHF: alu_result = a << b;
                    default:           alu_result = '0;
                endcase
            end
            cpu_pkg::OP1_ADDI,
            cpu_pkg::OP1_SW:   alu_result = a + b;  // SW gives its address
            cpu_pkg::OP1_ANDI: alu_result = a & b;
            cpu_pkg::OP1_ORI:  alu_result = a | b;
            cpu_pkg::OP1_XORI: alu_result = a ^ b;
            default:           alu_result = '0;
        endcase
    end

endmodule

/* rtl/branch_unit.sv */
module branch_unit (
    input  cpu_pkg::id_ex_t    id_ex,
    output cpu_pkg::redirect_t redirect
);

    logic           cond;
    cpu_pkg::data_t offset;
    cpu_pkg::data_t base;

    assign offset = id_ex.imm << 2;  // Word offset

    always_comb begin
        case (id_ex.op1)
            cpu_pkg::OP1_BEQ: cond = (id_ex.rs_val == id_ex.rt_val);
            cpu_pkg::OP1_BLT: cond = ($signed(id_ex.rs_val) < $signed(id_ex.rt_val));
            cpu_pkg::OP1_BLE: cond = ($signed(id_ex.rs_val) <= $signed(id_ex.rt_val));
            cpu_pkg::OP1_BNE: cond = (id_ex.rs_val != id_ex.rt_val);
            cpu_pkg::OP1_JAL: cond = 1'b1;
            default:          cond = 1'b0;
        endcase
    end

    // JAL is register relative, branches are PC relative
    assign base = (id_ex.op1 == cpu_pkg::OP1_JAL) ? id_ex.rs_val : id_ex.pc_plus;

    assign redirect.taken  = id_ex.valid && cond;
    assign redirect.target = base + offset;

endmodule

/* rtl/execute_stage.sv */
module execute_stage (
    input  logic               clk,
    input  logic               reset,
    input  cpu_pkg::id_ex_t    id_ex,
    output cpu_pkg::redirect_t redirect,
    output cpu_pkg::fwd_t      ex_fwd,
    output cpu_pkg::ex_wb_t    ex_wb
);

    cpu_pkg::data_t  alu_result;
    cpu_pkg::data_t  result;
    cpu_pkg::ex_wb_t ex_wb_d;

    alu_unit u_alu (
        .id_ex      (id_ex),
        .alu_result (alu_result)
    );

    branch_unit u_branch (
        .id_ex    (id_ex),
        .redirect (redirect)
    );

    // JAL writes its return address
    assign result = (id_ex.op1 == cpu_pkg::OP1_JAL) ? id_ex.pc_plus : alu_result;

    assign ex_fwd.wr_reg = id_ex.wr_reg;
    assign ex_fwd.dst    = id_ex.dst;
    assign ex_fwd.value  = result;

    always_comb begin
        ex_wb_d.wr_reg  = id_ex.wr_reg;
        ex_wb_d.dst     = id_ex.dst;
        ex_wb_d.result  = result;
        ex_wb_d.st_en   = id_ex.is_store;
        ex_wb_d.st_addr = alu_result;
        ex_wb_d.st_data = id_ex.rt_val;
    end

    // The executing instruction itself is never flushed
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            ex_wb <= '0;
        else
            ex_wb <= ex_wb_d;
    end

endmodule

/* rtl/writeback_io.sv */
module writeback_io #(
    parameter cpu_pkg::data_t ADDR_LEDR = 32'hFFFFF020,
    parameter cpu_pkg::data_t ADDR_HEX  = 32'hFFFFF000
) (
    input  logic             clk,
    input  logic             reset,
    input  cpu_pkg::ex_wb_t  ex_wb,
    output cpu_pkg::fwd_t    wb_fwd,
    output cpu_pkg::ledr_t   ledr,
    output cpu_pkg::hex_t    hex
);

    logic hit_ledr;
    logic hit_hex;

    // Register write request doubling as the older bypass source
    assign wb_fwd.wr_reg = ex_wb.wr_reg;
    assign wb_fwd.dst    = ex_wb.dst;
    assign wb_fwd.value  = ex_wb.result;

    // Stores elsewhere are dropped
    assign hit_ledr = ex_wb.st_en && (ex_wb.st_addr == ADDR_LEDR);
    assign hit_hex  = ex_wb.st_en && (ex_wb.st_addr == ADDR_HEX);

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            ledr <= '0;
        else if (hit_ledr)
            ledr <= cpu_pkg::ledr_t'(ex_wb.st_data);  // Low 10 bits
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            hex <= 24'hFEDEAD;  // Power-up pattern
        else if (hit_hex)
            hex <= cpu_pkg::hex_t'(ex_wb.st_data);
    end

endmodule

/* rtl/cpu_top.sv */
module cpu_top #(
    parameter cpu_pkg::pc_t   START_PC  = 32'h100,
    parameter cpu_pkg::data_t ADDR_HEX  = 32'hFFFFF000,
    parameter cpu_pkg::data_t ADDR_LEDR = 32'hFFFFF020
) (
    input  logic           clk,
    input  logic           reset,
    output cpu_pkg::pc_t   imem_addr,
    input  cpu_pkg::inst_t imem_data,
    output cpu_pkg::ledr_t ledr,
    output cpu_pkg::hex_t  hex
);

    cpu_pkg::inst_t     fetch_inst;
    cpu_pkg::pc_t       fetch_pc_plus;
    logic               fetch_valid;
    cpu_pkg::redirect_t redirect;
    cpu_pkg::id_ex_t    id_ex;
    cpu_pkg::ex_wb_t    ex_wb;
    cpu_pkg::fwd_t      ex_fwd;
    cpu_pkg::fwd_t      wb_fwd;

    fetch_stage #(
        .START_PC (START_PC)
    ) u_fetch (
        .clk           (clk),
        .reset         (reset),
        .redirect      (redirect),
        .imem_addr     (imem_addr),
        .imem_data     (imem_data),
        .fetch_inst    (fetch_inst),
        .fetch_pc_plus (fetch_pc_plus),
        .fetch_valid   (fetch_valid)
    );

    decode_stage u_decode (
        .clk           (clk),
        .reset         (reset),
        .fetch_inst    (fetch_inst),
        .fetch_pc_plus (fetch_pc_plus),
        .fetch_valid   (fetch_valid),
        .redirect      (redirect),
        .ex_fwd        (ex_fwd),
        .wb_fwd        (wb_fwd),
        .id_ex         (id_ex)
    );

    execute_stage u_execute (
        .clk      (clk),
        .reset    (reset),
        .id_ex    (id_ex),
        .redirect (redirect),
        .ex_fwd   (ex_fwd),
        .ex_wb    (ex_wb)
    );

    writeback_io #(
        .ADDR_LEDR (ADDR_LEDR),
        .ADDR_HEX  (ADDR_HEX)
    ) u_writeback (
        .clk    (clk),
        .reset  (reset),
        .ex_wb  (ex_wb),
        .wb_fwd (wb_fwd),
        .ledr   (ledr),
        .hex    (hex)
    );

endmodule

/* verification/tb_cpu.sv */
module tb_cpu;

    timeunit 1ns;
    timeprecision 100ps;

    localparam cpu_pkg::pc_t   START_PC     = 32'h100;
    localparam cpu_pkg::data_t ADDR_HEX     = 32'hFFFFF000;
    localparam cpu_pkg::data_t ADDR_LEDR    = 32'hFFFFF020;
    localparam int             NUM_TESTS    = 9;
    localparam int             MAX_WORDS    = 16;
    localparam int             RESET_CYCLES = 4;

    logic           clk;
    logic           reset;
    cpu_pkg::pc_t   imem_addr;
    cpu_pkg::inst_t imem_data;
    cpu_pkg::ledr_t ledr;
    cpu_pkg::hex_t  hex;

    // Program table
    string          test_name [NUM_TESTS];
    cpu_pkg::inst_t prog      [NUM_TESTS][MAX_WORDS];
    int             prog_len  [NUM_TESTS];
    cpu_pkg::ledr_t exp_ledr  [NUM_TESTS];
    cpu_pkg::hex_t  exp_hex   [NUM_TESTS];
    int             num_tests;
    int             cur;          // Program the ROM serves
    int             cycle_count;
    int             cycle_limit;

    cpu_top #(
        .START_PC  (START_PC),
        .ADDR_HEX  (ADDR_HEX),
        .ADDR_LEDR (ADDR_LEDR)
    ) DUT (
        .clk       (clk),
        .reset     (reset),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .ledr      (ledr),
        .hex       (hex)
    );

    always #20 clk = ~clk;

    task automatic abort_run(input string why);
        $display("TB FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic check_ledr(input string name, input cpu_pkg::ledr_t expected,
                              input cpu_pkg::ledr_t actual);
        if (actual !== expected) begin
            $display("error %s ledr: expected %h, actual %h", name, expected, actual);
            abort_run("ledr mismatch");
        end
    endtask

    task automatic check_hex(input string name, input cpu_pkg::hex_t expected,
                             input cpu_pkg::hex_t actual);
        if (actual !== expected) begin
            $display("error %s hex: expected %h, actual %h", name, expected, actual);
            abort_run("hex mismatch");
        end
    endtask

    // Fields in encoding order op2, rd, rs, rt
    function automatic cpu_pkg::inst_t rr_op(input cpu_pkg::op2_e f, input cpu_pkg::reg_idx_t rd,
                                             input cpu_pkg::reg_idx_t rs,
                                             input cpu_pkg::reg_idx_t rt);
        return {cpu_pkg::OP1_ALUR, f, 6'b000000, rd, rs, rt};
    endfunction

    function automatic cpu_pkg::inst_t ri_op(input cpu_pkg::op1_e op, input cpu_pkg::reg_idx_t rs,
                                             input cpu_pkg::reg_idx_t rt, input cpu_pkg::imm_t imm);
        return {op, 2'b00, imm, rs, rt};
    endfunction

    // Base r0 so the immediate alone makes the I/O address
    function automatic cpu_pkg::inst_t store_word(input cpu_pkg::reg_idx_t rt,
                                                  input cpu_pkg::data_t addr);
        return ri_op(cpu_pkg::OP1_SW, 4'd0, rt, addr[15:0]);
    endfunction

    function automatic cpu_pkg::inst_t rom_word(input int t, input cpu_pkg::pc_t addr);
        cpu_pkg::pc_t offset;
        offset = addr - START_PC;
        if (addr < START_PC || offset[1:0] != 2'b00 || offset >= MAX_WORDS * 4)
            return '0;
        return prog[t][offset[5:2]];
    endfunction

    function automatic int run_length(input int t);
        return 4 * prog_len[t] + 20;
    endfunction

    task automatic begin_test(input string name, input cpu_pkg::ledr_t ledr_exp,
                              input cpu_pkg::hex_t hex_exp);
        test_name[num_tests] = name;
        exp_ledr[num_tests]  = ledr_exp;
        exp_hex[num_tests]   = hex_exp;
        prog_len[num_tests]  = 0;
        num_tests++;
    endtask

    task automatic emit(input cpu_pkg::inst_t word);
        int t;
        t = num_tests - 1;
        if (prog_len[t] >= MAX_WORDS) begin
            abort_run("program table overflow");
        end else begin
            prog[t][prog_len[t]] = word;
            prog_len[t]++;
        end
    endtask

    task automatic end_program();
        emit(ri_op(cpu_pkg::OP1_BEQ, 4'd0, 4'd0, 16'hFFFF));  // Branch to itself
    endtask

    task automatic build_table();
        for (int t = 0; t < NUM_TESTS; t++)
            for (int w = 0; w < MAX_WORDS; w++)
                prog[t][w] = '0;
        num_tests = 0;

        begin_test("reset_values", 10'h000, 24'hFEDEAD);
        end_program();

        begin_test("alur_arith", 10'h099, 24'hFFFFAD);
        emit(ri_op(cpu_pkg::OP1_ADDI, 4'd0, 4'd1, 16'h00F3));
        emit(ri_op(cpu_pkg::OP1_ORI,  4'd0, 4'd2, 16'h005A));
        emit(rr_op(cpu_pkg::OP2_SUB,  4'd3, 4'd1, 4'd2));     // 0xF3 - 0x5A
        emit(rr_op(cpu_pkg::OP2_NAND, 4'd4, 4'd1, 4'd2));
        emit(store_word(4'd3, ADDR_LEDR));
        emit(store_word(4'd4, ADDR_HEX));
        end_program();

        begin_test("alur_logic_shift", 10'h3FE, 24'hFFFFFE);
        emit(ri_op(cpu_pkg::OP1_ADDI, 4'd0, 4'd1, 16'hFFF8));  // -8
        emit(ri_op(cpu_pkg::OP1_ADDI, 4'd0, 4'd2, 16'h0002));
        emit(rr_op(cpu_pkg::OP2_RSHF, 4'd3, 4'd1, 4'd2));     // -2
        emit(rr_op(cpu_pkg::OP2_LSHF, 4'd4, 4'd2, 4'd2));     // 8
        emit(rr_op(cpu_pkg::OP2_NXOR, 4'd5, 4'd3, 4'd4));     // 9
        emit(rr_op(cpu_pkg::OP2_NOR,  4'd6, 4'd4, 4'd2));     // ~0xA
        emit(rr_op(cpu_pkg::OP2_ADD,  4'd7, 4'd5, 4'd6));
        emit(store_word(4'd7, ADDR_LEDR));
        emit(store_word(4'd3, ADDR_HEX));
        end_program();

        begin_test("alur_compare", 10'h022, 24'h000020);
        emit(ri_op(cpu_pkg::OP1_ADDI, 4'd0, 4'd1, 16'hFFFD));  // -3
        emit(ri_op(cpu_pkg::OP1_ADDI, 4'd0, 4'd2, 16'h0005));
        emit(rr_op(cpu_pkg::OP2_LT,   4'd3, 4'd1, 4'd2));     // 1
        emit(rr_op(cpu_pkg::OP2_LE,   4'd4, 4'd2, 4'd1));     // 0
        emit(rr_op(cpu_pkg::OP2_EQ,   4'd5, 4'd1, 4'd1));     // 1
        emit(rr_op(cpu_pkg::OP2_NE,   4'd6, 4'd1, 4'd2));     // 1
        emit(rr_op(cpu_pkg::OP2_LSHF, 4'd7, 4'd6, 4'd2));     // 0x20
        emit(rr_op(cpu_pkg::OP2_LSHF, 4'd8, 4'd5, 4'd3));     // 0x02
        emit(rr_op(cpu_pkg::OP2_OR,   4'd9, 4'd7, 4'd8));
        emit(rr_op(cpu_pkg::OP2_XOR,  4'd10, 4'd9, 4'd4));
        emit(rr_op(cpu_pkg::OP2_AND,  4'd11, 4'd1, 4'd10));
        emit(store_word(4'd10, ADDR_LEDR));
        emit(store_word(4'd11, ADDR_HEX));
        end_program();

        begin_test("imm_sign_ext", 10'h1CB, 24'hFF8EFB);
        emit(ri_op(cpu_pkg::OP1_ADDI, 4'd0, 4'd1, 16'hFED4));  // -300
        emit(ri_op(cpu_pkg::OP1_ANDI, 4'd1, 4'd2, 16'h8F0F));
        emit(ri_op(cpu_pkg::OP1_XORI, 4'd2, 4'd3, 16'h00FF));
        emit(ri_op(cpu_pkg::OP1_ORI,  4'd0, 4'd4, 16'h1234));
        emit(ri_op(cpu_pkg::OP1_XORI, 4'd4, 4'd5, 16'hFFFF));  // Inverts all 32 bits
        emit(store_word(4'd3, ADDR_HEX));
        emit(store_word(4'd5, ADDR_LEDR));
        end_program();

        // Back to back chain against the same chain spread out by bubbles
        begin_test("forwarding", 10'h038, 24'h000038);
        emit(ri_op(cpu_pkg::OP1_ADDI, 4'd0, 4'd1, 16'h0003));
        emit(ri_op(cpu_pkg::OP1_ADDI, 4'd1, 4'd2, 16'h0004));
        emit(rr_op(cpu_pkg::OP2_LSHF, 4'd3, 4'd2, 4'd1));
        emit(store_word(4'd3, ADDR_LEDR));
        emit(ri_op(cpu_pkg::OP1_ADDI, 4'd0, 4'd5, 16'h0003));
        emit(32'h0);
        emit(32'h0);
        emit(ri_op(cpu_pkg::OP1_ADDI, 4'd5, 4'd6, 16'h0004));
        emit(32'h0);
        emit(32'h0);
        emit(rr_op(cpu_pkg::OP2_LSHF, 4'd7, 4'd6, 4'd5));
        emit(32'h0);
        emit(32'h0);
        emit(store_word(4'd7, ADDR_HEX));
        end_program();

        begin_test("branch_taken", 10'h000, 24'hFFFFFB);
        emit(ri_op(cpu_pkg::OP1_ADDI, 4'd0, 4'd1, 16'hFFFB));  // -5
        emit(ri_op(cpu_pkg::OP1_ADDI, 4'd0, 4'd2, 16'h0003));  // 3
        emit(store_word(4'd1, ADDR_HEX));
        emit(ri_op(cpu_pkg::OP1_BLT, 4'd1, 4'd2, 16'h0002));
        emit(store_word(4'd2, ADDR_LEDR));
        emit(store_word(4'd2, ADDR_HEX));
        emit(ri_op(cpu_pkg::OP1_BLE, 4'd1, 4'd2, 16'h0002));
        emit(store_word(4'd2, ADDR_LEDR));
        emit(store_word(4'd2, ADDR_HEX));
        emit(ri_op(cpu_pkg::OP1_BEQ, 4'd1, 4'd1, 16'h0002));
        emit(store_word(4'd2, ADDR_LEDR));
        emit(store_word(4'd2, ADDR_HEX));
        emit(ri_op(cpu_pkg::OP1_BNE, 4'd1, 4'd2, 16'h0002));
        emit(store_word(4'd2, ADDR_LEDR));
        emit(store_word(4'd2, ADDR_HEX));
        end_program();

        begin_test("branch_not_taken", 10'h00F, 24'hFFFFFB);
        emit(ri_op(cpu_pkg::OP1_ADDI, 4'd0, 4'd1, 16'hFFFB));  // -5
        emit(ri_op(cpu_pkg::OP1_ADDI, 4'd0, 4'd2, 16'h0003));  // 3
        emit(ri_op(cpu_pkg::OP1_BEQ,  4'd1, 4'd2, 16'h0002));
        emit(ri_op(cpu_pkg::OP1_ADDI, 4'd4, 4'd4, 16'h0001));
        emit(ri_op(cpu_pkg::OP1_BLT,  4'd2, 4'd1, 16'h0002));
        emit(ri_op(cpu_pkg::OP1_ADDI, 4'd4, 4'd4, 16'h0002));
        emit(ri_op(cpu_pkg::OP1_BLE,  4'd2, 4'd1, 16'h0002));
        emit(ri_op(cpu_pkg::OP1_ADDI, 4'd4, 4'd4, 16'h0004));
        emit(ri_op(cpu_pkg::OP1_BNE,  4'd1, 4'd1, 16'h0002));
        emit(ri_op(cpu_pkg::OP1_ADDI, 4'd4, 4'd4, 16'h0008));
        emit(store_word(4'd4, ADDR_LEDR));
        emit(store_word(4'd1, ADDR_HEX));
        end_program();

        // JAL at START_PC + 4 links START_PC + 8 and lands on word 5
        begin_test("jal", 10'h108, 24'h000108);
        emit(ri_op(cpu_pkg::OP1_ADDI, 4'd0, 4'd1, START_PC[15:0]));
        emit(ri_op(cpu_pkg::OP1_JAL,  4'd1, 4'd2, 16'h0005));
        emit(ri_op(cpu_pkg::OP1_ADDI, 4'd0, 4'd2, 16'h0001));  // Flushed
        emit(ri_op(cpu_pkg::OP1_ADDI, 4'd0, 4'd2, 16'h0002));  // Flushed
        emit(ri_op(cpu_pkg::OP1_ADDI, 4'd0, 4'd2, 16'h0003));  // Jumped over
        emit(store_word(4'd2, ADDR_LEDR));
        emit(store_word(4'd2, ADDR_HEX));
        end_program();
    endtask

    // Synchronous instruction ROM
    always @(posedge clk) begin
        imem_data <= rom_word(cur, imem_addr);
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("timeout after %0d cycles, the test sequence did not complete", cycle_count);
            abort_run("timeout");
        end
    end

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        imem_data   = '0;
        cur         = 0;
        cycle_count = 0;
        build_table();
        cycle_limit = 100;
        for (int t = 0; t < num_tests; t++)
            cycle_limit += RESET_CYCLES + run_length(t) + 2;

        for (int t = 0; t < num_tests; t++) begin
            @(posedge clk);
            reset <= 1'b1;
            cur   <= t;
            repeat (RESET_CYCLES) @(posedge clk);
            reset <= 1'b0;
            repeat (run_length(t)) @(posedge clk);
            @(negedge clk);  // Outputs settled
            check_ledr(test_name[t], exp_ledr[t], ledr);
            check_hex(test_name[t], exp_hex[t], hex);
            $display("%s: ledr %h hex %h", test_name[t], ledr, hex);
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

/* flist.f */
rtl/cpu_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/alu_unit.sv
rtl/branch_unit.sv
rtl/execute_stage.sv
rtl/writeback_io.sv
rtl/cpu_top.sv
verification/tb_cpu.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_cpu
FLIST      := flist.f
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary --timing -j 0
LINT_FLAGS := --lint-only -Wall --timing

SOURCES    := $(wildcard rtl/*.sv) $(wildcard verification/*.sv)

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)
